//--- common/poly_pkg.sv
package poly_pkg;

    //////////////////////////////////////////////////
    // Arithmetic and geometry
    //////////////////////////////////////////////////

    localparam int Q         = 12289;
    localparam int COEFF_W   = 14;
    localparam int DATA_W    = 16;
    localparam int N         = 256;
    localparam int IDX_W     = 8;
    localparam int SLOTS     = 4;
    localparam int SLOT_W    = 2;
    localparam int ADDR_W    = 11;
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 11'h400;
    localparam int NUM_LANES  = 2;
    localparam int LANE_LAT   = 3;
    localparam int NUM_PHASES = 3;
    // floor(2^28 / Q), shift equals the product width
    localparam int BARRETT_M  = (1 << (2 * COEFF_W)) / Q;

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL} alu_op_e;

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN} seq_state_e;

    typedef struct packed {
        alu_op_e           op;
        logic [SLOT_W-1:0] src_a;
        logic [SLOT_W-1:0] src_b;
        logic [SLOT_W-1:0] dst;
    } phase_t;

    // slot2 = s0 * s1, slot3 = s2 + s0, slot3 = s3 - s1
    localparam phase_t PROGRAM [NUM_PHASES] = '{
        '{op: OP_MUL, src_a: 2'd0, src_b: 2'd1, dst: 2'd2},
        '{op: OP_ADD, src_a: 2'd2, src_b: 2'd0, dst: 2'd3},
        '{op: OP_SUB, src_a: 2'd3, src_b: 2'd1, dst: 2'd3}
    };

    typedef struct packed {
        logic               valid;
        logic [SLOT_W-1:0]  slot;
        logic [IDX_W-1:0]   index;
        logic [COEFF_W-1:0] data;
    } ram_wr_t;

    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        logic [IDX_W-1:0]  index;
    } ram_rd_t;

    typedef struct packed {
        logic               valid;
        logic               last;
        alu_op_e            op;
        logic [SLOT_W-1:0]  dst;
        logic [IDX_W-1:0]   index;
        logic [COEFF_W-1:0] a;
        logic [COEFF_W-1:0] b;
    } lane_item_t;

    typedef struct packed {
        logic               valid;
        logic               last;
        logic [SLOT_W-1:0]  dst;
        logic [IDX_W-1:0]   index;
        logic [COEFF_W-1:0] value;
    } lane_result_t;

    //////////////////////////////////////////////////
    // Wishbone classic
    //////////////////////////////////////////////////

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

//--- poly_engine/mod_q_lane.sv
module mod_q_lane (
    input  logic                   clk,
    input  logic                   rst,
    input  poly_pkg::lane_item_t   item,
    output poly_pkg::lane_result_t result
);
    import poly_pkg::*;

    localparam int PROD_W = 2 * COEFF_W;
    localparam int MUL_W  = PROD_W + $clog2(BARRETT_M + 1);

    logic [PROD_W-1:0]       x_d;
    logic [PROD_W-1:0]       x1_q;
    logic [MUL_W-1:0]        prod_m;
    logic [MUL_W-PROD_W-1:0] quot;
    logic [PROD_W-1:0]       rem;
    logic [COEFF_W:0]        r2_q;
    logic [COEFF_W-1:0]      val3_q;
    lane_result_t            meta_in;
    lane_result_t            meta_q [LANE_LAT];

    // Stage 1 raw value; Q added before subtracting keeps it positive
    always_comb begin
        case (item.op)
            OP_ADD:  x_d = PROD_W'(item.a) + PROD_W'(item.b);
            OP_SUB:  x_d = PROD_W'(item.a) + PROD_W'(Q) - PROD_W'(item.b);
            OP_MUL:  x_d = PROD_W'(item.a) * PROD_W'(item.b);
            default: x_d = '0;
        endcase
    end

    // Stage 2 Barrett estimate, remainder below 2Q
    always_comb begin
        prod_m = MUL_W'(x1_q) * MUL_W'(BARRETT_M);
        quot   = prod_m[MUL_W-1:PROD_W];
        rem    = x1_q - PROD_W'(quot) * PROD_W'(Q);
    end

    always_ff @(posedge clk) begin
        x1_q   <= x_d;
        r2_q   <= rem[COEFF_W:0];
        val3_q <= (r2_q >= (COEFF_W+1)'(Q)) ? COEFF_W'(r2_q - (COEFF_W+1)'(Q))
                                            : COEFF_W'(r2_q);
    end

    assign meta_in = '{valid: item.valid, last: item.last, dst: item.dst,
                       index: item.index, value: '0};

    // Side band follows the data
    always_ff @(posedge clk) begin
        meta_q[0] <= meta_in;
        for (int s = 1; s < LANE_LAT; s++) begin
            meta_q[s] <= meta_q[s-1];
        end
        if (rst) begin
            for (int s = 0; s < LANE_LAT; s++) begin
                meta_q[s].valid <= 1'b0;
            end
        end
    end

    always_comb begin
        result       = meta_q[LANE_LAT-1];
        result.value = val3_q;
    end

endmodule

//--- poly_engine/operand_fetch.sv
module operand_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        phase_go,
    input  poly_pkg::phase_t            phase,
    output poly_pkg::ram_rd_t           rd_a,
    output poly_pkg::ram_rd_t           rd_b,
    input  logic [poly_pkg::DATA_W-1:0] q_a,
    input  logic [poly_pkg::DATA_W-1:0] q_b,
    output poly_pkg::lane_item_t        items [poly_pkg::NUM_LANES]
);
    import poly_pkg::*;

    phase_t           phase_q;
    logic             active_q;
    logic [IDX_W-1:0] idx_q;
    logic             item_vld_q;
    logic             item_last_q;
    logic [IDX_W-1:0] item_idx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q   <= 1'b0;
            idx_q      <= '0;
            item_vld_q <= 1'b0;
        end else begin
            item_vld_q <= active_q;
            if (phase_go) begin
                active_q <= 1'b1;
                idx_q    <= '0;
            end else if (active_q) begin
                active_q <= idx_q != IDX_W'(N - 1);
                idx_q    <= idx_q + 1'b1;
            end
        end
    end

    // Metadata lines up with the RAM read latency
    always_ff @(posedge clk) begin
        if (phase_go) begin
            phase_q <= phase;
        end
        item_idx_q  <= idx_q;
        item_last_q <= idx_q == IDX_W'(N - 1);
    end

    assign rd_a = '{slot: phase_q.src_a, index: idx_q};
    assign rd_b = '{slot: phase_q.src_b, index: idx_q};

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            items[l].valid = item_vld_q && (int'(item_idx_q) % NUM_LANES == l);
            items[l].last  = item_last_q;
            items[l].op    = phase_q.op;
            items[l].dst   = phase_q.dst;
            items[l].index = item_idx_q;
            items[l].a     = q_a[COEFF_W-1:0];
            items[l].b     = q_b[COEFF_W-1:0];
        end
    end

endmodule

//--- poly_engine/phase_sequencer.sv
module phase_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             phase_done,
    output logic             phase_go,
    output poly_pkg::phase_t phase,
    output logic             busy,
    output logic             done
);
    import poly_pkg::*;

    localparam int PH_W = $clog2(NUM_PHASES);

    seq_state_e      state_q;
    logic [PH_W-1:0] phase_q;
    logic            done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            phase_q <= '0;
            done_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        phase_q <= '0;
                        done_q  <= 1'b0;
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    state_q <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    // Next phase only once the last write is in
                    if (phase_done) begin
                        if (phase_q == PH_W'(NUM_PHASES - 1)) begin
                            done_q  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            phase_q <= phase_q + 1'b1;
                            state_q <= ST_ISSUE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign phase_go = state_q == ST_ISSUE;
    assign phase    = PROGRAM[phase_q];
    assign busy     = state_q != ST_IDLE;
    assign done     = done_q;

endmodule

//--- poly_engine/result_writeback.sv
module result_writeback (
    input  logic                   clk,
    input  logic                   rst,
    input  poly_pkg::lane_result_t results [poly_pkg::NUM_LANES],
    output poly_pkg::ram_wr_t      wr,
    output logic                   phase_done
);
    import poly_pkg::*;

    lane_result_t sel;
    ram_wr_t      wr_q;
    logic         done_q;

    // Lanes are staggered, so one valid at most
    always_comb begin
        sel = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (results[l].valid) begin
                sel = results[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q.valid <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            wr_q.valid <= sel.valid;
            done_q     <= sel.valid && sel.last;
        end
        wr_q.slot  <= sel.dst;
        wr_q.index <= sel.index;
        wr_q.data  <= sel.value;
    end

    assign wr         = wr_q;
    assign phase_done = done_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the poly_engine testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_poly_engine -o sim_poly_engine

./obj_dir/sim_poly_engine | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- testbench/poly_engine_assertions.sv
module poly_engine_assertions (
    input logic                   clk,
    input logic                   rst,
    input poly_pkg::wb_rsp_t      wb_rsp,
    input poly_pkg::lane_result_t results [poly_pkg::NUM_LANES]
);
    timeunit 1ns;
    timeprecision 1ps;
    import poly_pkg::*;

    logic [NUM_LANES-1:0] valid_vec;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            valid_vec[l] = results[l].valid;
        end
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Wishbone ack held for more than one cycle");

    // Lanes are staggered by the fetch
    one_result: assert property (@(posedge clk) disable iff (rst)
        $onehot0(valid_vec))
        else $error("More than one lane result valid in a cycle");

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        value_below_q: assert property (@(posedge clk) disable iff (rst)
            results[l].valid |-> results[l].value < COEFF_W'(Q))
            else $error("Lane %0d result at or above the modulus", l);
    end

endmodule

bind poly_engine_top poly_engine_assertions u_assertions (.clk, .rst, .wb_rsp, .results);

//--- testbench/tb_poly_engine.sv
module tb_poly_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import poly_pkg::*;

    localparam logic [31:0] SEED = 32'hd6b1_9af0;
    // About 4600 bus cycles of 3 clocks each plus five runs of about 800 clocks
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int ACK_LIMIT      = 16;
    localparam int POLL_LIMIT     = 1000;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    int      cycles = 0;
    int      errors = 0;
    int      checks = 0;
    int      tests  = 0;
    int      model [SLOTS][N];

    poly_engine_top UUT (.clk, .rst, .wb_req, .wb_rsp);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    task automatic bus_cycle(input logic write, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: wdat};
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        rdat = wb_rsp.dat;
        assert (wb_rsp.ack) else begin
            $display("No Wishbone ack for address %h within %0d cycles", adr, ACK_LIMIT);
            errors++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        logic [DATA_W-1:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic check_value(input string test, input string what, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", test, what, exp, act);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int apply_op(alu_op_e op, int a, int b);
        case (op)
            OP_ADD:  return (a + b) % Q;
            OP_SUB:  return (a - b + Q) % Q;
            default: return (a * b) % Q;
        endcase
    endfunction

    task automatic run_program();
        phase_t ph;
        for (int p = 0; p < NUM_PHASES; p++) begin
            ph = PROGRAM[p];
            for (int i = 0; i < N; i++) begin
                model[ph.dst][i] = apply_op(ph.op, model[ph.src_a][i], model[ph.src_b][i]);
            end
        end
    endtask

    task automatic fill_random();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < N; i++) begin
                model[s][i] = int'($urandom % Q);
            end
        end
    endtask

    // All four pairings of 0 and Q-1
    task automatic fill_edge();
        for (int i = 0; i < N; i++) begin
            model[0][i] = (i % 2 == 1) ? Q - 1 : 0;
            model[1][i] = ((i / 2) % 2 == 1) ? Q - 1 : 0;
        end
    endtask

    task automatic write_inputs();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < N; i++) begin
                wb_write(ADDR_W'(s * N + i), DATA_W'(model[s][i]));
            end
        end
    endtask

    task automatic compare_slot(input string test, input int slot);
        logic [DATA_W-1:0] d;
        for (int i = 0; i < N; i++) begin
            wb_read(ADDR_W'(slot * N + i), d);
            check_value(test, $sformatf("slot %0d index %0d", slot, i), model[slot][i], int'(d));
        end
    endtask

    task automatic wait_done(input string test);
        logic [DATA_W-1:0] status;
        int polls;
        polls = 0;
        do begin
            wb_read(CTRL_ADDR, status);
            polls++;
        end while (!status[1] && polls < POLL_LIMIT);
        assert (status[1]) else begin
            $display("%s: run did not finish within %0d status polls", test, POLL_LIMIT);
            errors++;
        end
        check_value(test, "status after run", 2, int'(status[1:0]));
    endtask

    task automatic report_test(input string test, input int errors_before);
        tests++;
        $display("%-14s finished, %0d failed checks", test, errors - errors_before);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic after_reset();
        logic [DATA_W-1:0] d;
        int e0;
        e0 = errors;
        wb_read(CTRL_ADDR, d);
        check_value("after_reset", "status", 0, int'(d[1:0]));
        report_test("after_reset", e0);
    endtask

    task automatic load_readback();
        int e0;
        e0 = errors;
        fill_random();
        write_inputs();
        compare_slot("load_readback", 0);
        compare_slot("load_readback", 1);
        report_test("load_readback", e0);
    endtask

    task automatic full_run();
        int e0;
        e0 = errors;
        run_program();
        wb_write(CTRL_ADDR, 16'h1);
        wait_done("full_run");
        for (int s = 0; s < SLOTS; s++) begin
            compare_slot("full_run", s);
        end
        report_test("full_run", e0);
    endtask

    task automatic edge_values();
        int e0;
        e0 = errors;
        fill_edge();
        write_inputs();
        run_program();
        wb_write(CTRL_ADDR, 16'h1);
        wait_done("edge_values");
        compare_slot("edge_values", 2);
        compare_slot("edge_values", 3);
        report_test("edge_values", e0);
    endtask

    task automatic busy_access();
        logic [DATA_W-1:0] d;
        int e0;
        e0 = errors;
        wb_write(CTRL_ADDR, 16'h1);
        wb_read(CTRL_ADDR, d);
        check_value("busy_access", "status during run", 1, int'(d[1:0]));
        wb_read(ADDR_W'(5), d);
        check_value("busy_access", "read while busy", 0, int'(d));
        wb_write(ADDR_W'(5), DATA_W'((model[0][5] + 1) % Q));
        wb_write(CTRL_ADDR, 16'h1);
        wait_done("busy_access");
        wb_read(ADDR_W'(5), d);
        check_value("busy_access", "slot 0 index 5", model[0][5], int'(d));
        compare_slot("busy_access", 2);
        compare_slot("busy_access", 3);
        report_test("busy_access", e0);
    endtask

    task automatic rerun();
        logic [DATA_W-1:0] d;
        int e0;
        e0 = errors;
        wb_write(CTRL_ADDR, 16'h1);
        wb_read(CTRL_ADDR, d);
        check_value("rerun", "status after start", 1, int'(d[1:0]));
        wait_done("rerun");
        fill_random();
        write_inputs();
        run_program();
        wb_write(CTRL_ADDR, 16'h1);
        wait_done("rerun");
        compare_slot("rerun", 2);
        compare_slot("rerun", 3);
        report_test("rerun", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst    = 1'b1;
        wb_req = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        load_readback();
        full_run();
        edge_values();
        busy_access();
        rerun();
        $display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/coeff_ram.sv
module coeff_ram (
    input  logic                          clk,
    input  poly_pkg::ram_wr_t             wr,
    input  poly_pkg::ram_rd_t             rd_a,
    input  poly_pkg::ram_rd_t             rd_b,
    output logic [poly_pkg::DATA_W-1:0]   q_a,
    output logic [poly_pkg::DATA_W-1:0]   q_b
);
    import poly_pkg::*;

    // Slot in the upper address bits
    logic [COEFF_W-1:0] mem [SLOTS*N];

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[{wr.slot, wr.index}] <= wr.data;
        end
    end

    // Registered reads, old data on a colliding write
    always_ff @(posedge clk) begin
        q_a <= DATA_W'(mem[{rd_a.slot, rd_a.index}]);
        q_b <= DATA_W'(mem[{rd_b.slot, rd_b.index}]);
    end

endmodule

//--- verilog/host_port.sv
module host_port (
    input  logic                        clk,
    input  logic                        rst,
    input  poly_pkg::wb_req_t           wb_req,
    output poly_pkg::wb_rsp_t           wb_rsp,
    input  logic                        busy,
    input  logic                        done,
    output logic                        start,
    input  poly_pkg::ram_wr_t           eng_wr,
    input  poly_pkg::ram_rd_t           eng_rd_a,
    output poly_pkg::ram_wr_t           ram_wr,
    output poly_pkg::ram_rd_t           rd_addr_a,
    input  logic [poly_pkg::DATA_W-1:0] rd_data_a
);
    import poly_pkg::*;

    logic    req;
    logic    is_ctrl;
    logic    is_ram;
    logic    ack_q;
    logic    ctrl_rd_q;
    logic    ram_rd_q;
    logic    [1:0] status_q;
    ram_wr_t host_wr;
    ram_rd_t host_rd;

    // New request only while no ack is pending
    assign req     = wb_req.cyc && wb_req.stb && !ack_q;
    assign is_ctrl = wb_req.adr == CTRL_ADDR;
    assign is_ram  = wb_req.adr < CTRL_ADDR;
    assign start   = req && wb_req.we && is_ctrl && wb_req.dat[0] && !busy;

    assign host_rd.slot  = wb_req.adr[IDX_W +: SLOT_W];
    assign host_rd.index = wb_req.adr[IDX_W-1:0];

    assign host_wr.valid = req && wb_req.we && is_ram;
    assign host_wr.slot  = host_rd.slot;
    assign host_wr.index = host_rd.index;
    assign host_wr.data  = wb_req.dat[COEFF_W-1:0];

    // Engine owns write port and port A during a run
    assign ram_wr    = busy ? eng_wr : host_wr;
    assign rd_addr_a = busy ? eng_rd_a : host_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            ctrl_rd_q <= 1'b0;
            ram_rd_q  <= 1'b0;
        end else begin
            ack_q     <= req;
            ctrl_rd_q <= req && !wb_req.we && is_ctrl;
            ram_rd_q  <= req && !wb_req.we && is_ram && !busy;
        end
        status_q <= {done, busy};
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = ctrl_rd_q ? DATA_W'(status_q) :
                        ram_rd_q  ? rd_data_a : '0;

endmodule

//--- verilog/poly_engine_top.sv
module poly_engine_top (
    input  logic              clk,
    input  logic              rst,
    input  poly_pkg::wb_req_t wb_req,
    output poly_pkg::wb_rsp_t wb_rsp
);
    import poly_pkg::*;

    logic              start;
    logic              busy;
    logic              done;
    logic              phase_go;
    logic              phase_done;
    phase_t            phase;
    ram_wr_t           ram_wr;
    ram_wr_t           eng_wr;
    ram_rd_t           rd_addr_a;
    ram_rd_t           eng_rd_a;
    ram_rd_t           rd_addr_b;
    logic [DATA_W-1:0] q_a;
    logic [DATA_W-1:0] q_b;
    lane_item_t        items [NUM_LANES];
    lane_result_t      results [NUM_LANES];

    host_port u_host (
        .clk, .rst, .wb_req, .wb_rsp, .busy, .done, .start, .eng_wr, .eng_rd_a,
        .ram_wr, .rd_addr_a, .rd_data_a(q_a)
    );

    coeff_ram u_ram (
        .clk, .wr(ram_wr), .rd_a(rd_addr_a), .rd_b(rd_addr_b), .q_a, .q_b
    );

    phase_sequencer u_seq (
        .clk, .rst, .start, .phase_done, .phase_go, .phase, .busy, .done
    );

    operand_fetch u_fetch (
        .clk, .rst, .phase_go, .phase, .rd_a(eng_rd_a), .rd_b(rd_addr_b),
        .q_a, .q_b, .items
    );

    //////////////////////////////////////////////////
    // Arithmetic lanes
    //////////////////////////////////////////////////

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        mod_q_lane u_lane (.clk, .rst, .item(items[l]), .result(results[l]));
    end

    result_writeback u_wb (
        .clk, .rst, .results, .wr(eng_wr), .phase_done
    );

endmodule

//--- vlog.f
common/poly_pkg.sv
verilog/coeff_ram.sv
verilog/host_port.sv
poly_engine/phase_sequencer.sv
poly_engine/operand_fetch.sv
poly_engine/mod_q_lane.sv
poly_engine/result_writeback.sv
verilog/poly_engine_top.sv
testbench/poly_engine_assertions.sv
testbench/tb_poly_engine.sv
